//--- list.f
+incdir+hw
hw/fight_pkg.sv
hw/contact_detect.sv
hw/player_control.sv
hw/player_physics.sv
hw/round_referee.sv
hw/fight_top.sv
test/tb_clock.sv
test/fight_sva.sv
test/tb_fight.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_fight
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/tb_fight.sv
`timescale 1ns/1ps
`include "fight_settings.svh"

module tb_fight;

    localparam int x_limit      = `FIGHT_ARENA_W - `FIGHT_SPRITE_W;
    localparam int hold_done    = `FIGHT_RESTART_TICKS;
    localparam int random_limit = 3000;

    logic                  CLK_20Hz;
    logic                  rst_n;
    fight_pkg::pad_t       pad1;
    fight_pkg::pad_t       pad2;
    logic                  restart_sw;
    fight_pkg::game_view_t view;

    // reference state, advanced once per tick
    fight_pkg::game_view_t last_view;
    fight_pkg::attack_t    older_att1;
    fight_pkg::attack_t    older_att2;
    fight_pkg::pad_t       seen_pad1;
    fight_pkg::pad_t       seen_pad2;
    logic                  seen_restart_sw;
    logic                  seen_attack1;
    int                    stun1_left;
    int                    stun2_left;
    int                    hold_cnt;
    logic                  restart_due;
    logic [31:0]           lfsr;

    tb_clock #(.PERIOD_NS(100)) u_clock (
        .CLK_20Hz (CLK_20Hz),
        .rst_n    (rst_n)
    );

    fight_top u_dut (
        .CLK_20Hz   (CLK_20Hz),
        .rst_n      (rst_n),
        .pad1       (pad1),
        .pad2       (pad2),
        .restart_sw (restart_sw),
        .view       (view)
    );

    // --------------------------------------------------------------------------
    // random source and reference rules
    // --------------------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0])
        begin
            next = next ^ 32'hD000_0001;
        end
        return next;
    endfunction

    task automatic draw_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b = lfsr[0];
    endtask

    // walks mostly toward the given side, jumps now and then
    task automatic random_pad(input logic go_right, output fight_pkg::pad_t p);
        logic [8:0] b;
        for (int i = 0; i < 9; i++)
        begin
            draw_bit(b[i]);
        end
        p.right  = go_right ? (b[0] | b[1]) : (b[0] & b[1]);
        p.left   = go_right ? (b[2] & b[3]) : (b[2] | b[3]);
        p.up     = b[4] & b[5] & b[6];
        p.down   = b[7];
        p.attack = b[8];
    endtask

    // attack button picks the kind, up outranks down
    function automatic fight_pkg::attack_t attack_of(input fight_pkg::pad_t p);
        if (!p.attack)
        begin
            return fight_pkg::attack_none;
        end
        if (p.up)
        begin
            return fight_pkg::attack_super;
        end
        if (p.down)
        begin
            return fight_pkg::attack_special;
        end
        return fight_pkg::attack_normal;
    endfunction

    function automatic int damage_of(input fight_pkg::attack_t kind);
        case (kind)
            fight_pkg::attack_normal:  return `FIGHT_DMG_NORMAL;
            fight_pkg::attack_special: return `FIGHT_DMG_SPECIAL;
            fight_pkg::attack_super:   return `FIGHT_DMG_SUPER;
            default:                   return 0;
        endcase
    endfunction

    function automatic fight_pkg::health_t after_hit(input fight_pkg::health_t health,
                                                     input fight_pkg::attack_t kind);
        int left_over;
        left_over = int'(health) - damage_of(kind);
        return (left_over > 0) ? fight_pkg::health_t'(left_over) : '0;
    endfunction

    function automatic fight_pkg::pos_t start_pos(input int x);
        fight_pkg::pos_t p;
        p.x = fight_pkg::coord_t'(x);
        p.y = fight_pkg::coord_t'(`FIGHT_GROUND_Y);
        return p;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            abort_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected));
        end
    endtask

    task automatic check_idle();
        check_value("view.p1_pos", view.p1_pos, start_pos(`FIGHT_P1_START_X));
        check_value("view.p2_pos", view.p2_pos, start_pos(`FIGHT_P2_START_X));
        check_value("view.health1", view.health1, `FIGHT_HEALTH_MAX);
        check_value("view.health2", view.health2, `FIGHT_HEALTH_MAX);
        check_value("view.winner", view.winner, fight_pkg::win_none);
        check_value("view.p1_attack", view.p1_attack, fight_pkg::attack_none);
        check_value("view.p2_attack", view.p2_attack, fight_pkg::attack_none);
    endtask

    // one tick of the reference, compared against the new view
    task automatic check_rules();
        fight_pkg::health_t  h1;
        fight_pkg::health_t  h2;
        fight_pkg::winner_t  win;
        fight_pkg::contact_t exp_contact;
        fight_pkg::attack_t  exp_att1;
        fight_pkg::attack_t  exp_att2;
        logic                hit1;
        logic                hit2;
        logic                hold_req;
        logic                restart_now;
        int                  gap;

        hold_req    = seen_restart_sw
                      || (seen_attack1 && (last_view.winner != fight_pkg::win_none));
        restart_now = restart_due;
        restart_due = (hold_cnt == hold_done);
        if (!hold_req)
        begin
            hold_cnt = 0;
        end
        else if (hold_cnt != hold_done + 1)
        begin
            hold_cnt = hold_cnt + 1;
        end

        hit1 = 1'b0;
        hit2 = 1'b0;
        if (restart_now)
        begin
            h1  = `FIGHT_HEALTH_MAX;
            h2  = `FIGHT_HEALTH_MAX;
            win = fight_pkg::win_none;
            stun1_left = 0;
            stun2_left = 0;
            check_value("view.p1_pos", view.p1_pos, start_pos(`FIGHT_P1_START_X));
            check_value("view.p2_pos", view.p2_pos, start_pos(`FIGHT_P2_START_X));
        end
        else
        begin
            h1  = last_view.health1;
            h2  = last_view.health2;
            win = last_view.winner;
            if (win == fight_pkg::win_none)
            begin
                hit1 = (last_view.p2_attack != fight_pkg::attack_none)
                       && (older_att2 == fight_pkg::attack_none) && last_view.contact.in_range;
                hit2 = (last_view.p1_attack != fight_pkg::attack_none)
                       && (older_att1 == fight_pkg::attack_none) && last_view.contact.in_range;
                if (hit1)
                begin
                    h1 = after_hit(h1, last_view.p2_attack);
                end
                if (hit2)
                begin
                    h2 = after_hit(h2, last_view.p1_attack);
                end
                if ((h1 == '0) && (h2 == '0))
                begin
                    win = fight_pkg::win_draw;
                end
                else if (h1 == '0)
                begin
                    win = fight_pkg::win_p2;
                end
                else if (h2 == '0)
                begin
                    win = fight_pkg::win_p1;
                end
            end
            stun1_left = hit1 ? `FIGHT_STUN_TICKS : ((stun1_left > 0) ? stun1_left - 1 : 0);
            stun2_left = hit2 ? `FIGHT_STUN_TICKS : ((stun2_left > 0) ? stun2_left - 1 : 0);
        end
        check_value("view.health1", view.health1, h1);
        check_value("view.health2", view.health2, h2);
        check_value("view.winner", view.winner, win);

        // a stunned fighter or a finished round shows no attack
        exp_att1 = ((stun1_left > 0) || (win != fight_pkg::win_none))
                   ? fight_pkg::attack_none : attack_of(seen_pad1);
        exp_att2 = ((stun2_left > 0) || (win != fight_pkg::win_none))
                   ? fight_pkg::attack_none : attack_of(seen_pad2);
        check_value("view.p1_attack", view.p1_attack, exp_att1);
        check_value("view.p2_attack", view.p2_attack, exp_att2);

        if ((int'(view.p1_pos.x) > x_limit) || (int'(view.p2_pos.x) > x_limit))
        begin
            abort_run("a fighter left the arena");
        end
        gap = int'(view.p1_pos.x) - int'(view.p2_pos.x);
        gap = (gap < 0) ? -gap : gap;
        if (gap < `FIGHT_SPRITE_W)
        begin
            abort_run("the fighters came closer than one sprite width");
        end
        exp_contact.touching        = gap <= `FIGHT_SPRITE_W;
        exp_contact.in_range        = gap <= `FIGHT_HIT_RANGE;
        exp_contact.p1_facing_right = view.p1_pos.x < view.p2_pos.x;
        check_value("view.contact", view.contact, exp_contact);

        older_att1 = last_view.p1_attack;
        older_att2 = last_view.p2_attack;
        last_view  = view;
    endtask

    // drive on the rising edge, check once outputs settle
    task automatic step_cycle(input fight_pkg::pad_t p1, input fight_pkg::pad_t p2,
                              input logic rs);
        @(posedge CLK_20Hz);
        pad1       <= p1;
        pad2       <= p2;
        restart_sw <= rs;
        @(negedge CLK_20Hz);
        check_rules();
        seen_pad1       = p1;
        seen_pad2       = p2;
        seen_restart_sw = rs;
        seen_attack1    = p1.attack;
    endtask

    // --------------------------------------------------------------------------
    // test sequence
    // --------------------------------------------------------------------------
    initial
    begin
        int                n;
        logic              got_winner;
        logic              in_air;
        logic [3:0]        rs_bits;
        fight_pkg::pad_t   p1;
        fight_pkg::pad_t   p2;
        fight_pkg::coord_t x0;

        pad1       = '0;
        pad2       = '0;
        restart_sw = 1'b0;
        lfsr       = 32'h59d2_e60e;

        n = 0;
        while ((rst_n !== 1'b1) && (n < 10))
        begin
            @(negedge CLK_20Hz);
            n++;
        end
        if (rst_n !== 1'b1)
        begin
            abort_run("reset was never released");
        end
        check_idle();
        last_view       = view;
        older_att1      = fight_pkg::attack_none;
        older_att2      = fight_pkg::attack_none;
        seen_pad1       = '0;
        seen_pad2       = '0;
        seen_restart_sw = 1'b0;
        seen_attack1    = 1'b0;
        stun1_left      = 0;
        stun2_left      = 0;
        hold_cnt        = 0;
        restart_due     = 1'b0;

        // fight until someone is knocked out
        got_winner = 1'b0;
        n = 0;
        while (!got_winner && (n < random_limit))
        begin
            random_pad(1'b1, p1);
            random_pad(1'b0, p2);
            for (int i = 0; i < 4; i++)
            begin
                draw_bit(rs_bits[i]);
            end
            step_cycle(p1, p2, &rs_bits);
            got_winner = view.winner != fight_pkg::win_none;
            n++;
        end
        if (!got_winner)
        begin
            abort_run("no winner was decided during the random fight");
        end

        // keep pressing after the knockout, nothing may change
        for (n = 0; n < 20; n++)
        begin
            random_pad(1'b1, p1);
            random_pad(1'b0, p2);
            step_cycle(p1, p2, 1'b0);
        end

        // hold restart, then wait for the new round
        for (n = 0; n < hold_done + 2; n++)
        begin
            step_cycle('0, '0, 1'b1);
        end
        n = 0;
        while ((view.winner != fight_pkg::win_none) && (n < 10))
        begin
            step_cycle('0, '0, 1'b0);
            n++;
        end
        if (view.winner != fight_pkg::win_none)
        begin
            abort_run("the round did not restart after holding the switch");
        end
        check_idle();

        // single left press on p1
        x0 = view.p1_pos.x;
        p1 = '0;
        p1.left = 1'b1;
        step_cycle(p1, '0, 1'b0);
        step_cycle('0, '0, 1'b0);
        check_value("view.p1_pos.x", view.p1_pos.x, x0);
        step_cycle('0, '0, 1'b0);
        check_value("view.p1_pos.x", view.p1_pos.x, fight_pkg::coord_t'(x0 - 1'b1));
        step_cycle('0, '0, 1'b0);
        check_value("view.p1_pos.x", view.p1_pos.x, fight_pkg::coord_t'(x0 - 1'b1));

        // single jump on p2
        p2 = '0;
        p2.up = 1'b1;
        step_cycle('0, p2, 1'b0);
        in_air = 1'b0;
        n = 0;
        while ((n < 2 * `FIGHT_JUMP_TICKS + 2)
               && !(in_air && (int'(view.p2_pos.y) == `FIGHT_GROUND_Y)))
        begin
            step_cycle('0, '0, 1'b0);
            if (int'(view.p2_pos.y) != `FIGHT_GROUND_Y)
            begin
                in_air = 1'b1;
            end
            n++;
        end
        if (!in_air)
        begin
            abort_run("the jump never left the floor");
        end
        else if (int'(view.p2_pos.y) != `FIGHT_GROUND_Y)
        begin
            abort_run("the jump did not land in time");
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- test/fight_sva.sv
`timescale 1ns/1ps
`include "fight_settings.svh"

module fight_sva (
    input logic                   CLK_20Hz,
    input logic                   rst_n,
    input fight_pkg::game_view_t  view
);

    fight_pkg::coord_t gap;

    assign gap = (view.p1_pos.x < view.p2_pos.x) ? view.p2_pos.x - view.p1_pos.x
                                                 : view.p1_pos.x - view.p2_pos.x;

    // --------------------------------------------------------------------------
    // floor bounds and spacing
    // --------------------------------------------------------------------------
    p1_in_arena: assert property (@(posedge CLK_20Hz) disable iff (!rst_n)
        int'(view.p1_pos.x) <= `FIGHT_ARENA_W - `FIGHT_SPRITE_W)
        else $error("p1 x outside the arena");

    p2_in_arena: assert property (@(posedge CLK_20Hz) disable iff (!rst_n)
        int'(view.p2_pos.x) <= `FIGHT_ARENA_W - `FIGHT_SPRITE_W)
        else $error("p2 x outside the arena");

    no_overlap: assert property (@(posedge CLK_20Hz) disable iff (!rst_n)
        int'(gap) >= `FIGHT_SPRITE_W)
        else $error("fighters closer than one sprite width");

    // finished round, no attacks and the winner holds until restart
    frozen_attacks: assert property (@(posedge CLK_20Hz) disable iff (!rst_n)
        (view.winner != fight_pkg::win_none) |->
        (view.p1_attack == fight_pkg::attack_none) && (view.p2_attack == fight_pkg::attack_none))
        else $error("attack active after the round ended");

    winner_held: assert property (@(posedge CLK_20Hz) disable iff (!rst_n)
        (view.winner != fight_pkg::win_none) |=>
        (view.winner == $past(view.winner)) || (view.winner == fight_pkg::win_none))
        else $error("winner changed without a restart");

endmodule

bind fight_top fight_sva u_sva (
    .CLK_20Hz (CLK_20Hz),
    .rst_n    (rst_n),
    .view     (view)
);

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic CLK_20Hz,
    output logic rst_n
);

    logic clk_q = 1'b0;

    initial
    begin
        forever
        begin
            #(PERIOD_NS / 2) clk_q = ~clk_q;
        end
    end

    // reset covers the first two rising edges
    initial
    begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk_q);
        rst_n <= 1'b1;
    end

    assign CLK_20Hz = clk_q;

endmodule

//--- hw/fight_top.sv
`timescale 1ns/1ps
`include "fight_settings.svh"

module fight_top (
    input  logic                   CLK_20Hz,
    input  logic                   rst_n,
    input  fight_pkg::pad_t        pad1,
    input  fight_pkg::pad_t        pad2,
    input  logic                   restart_sw,
    output fight_pkg::game_view_t  view
);

    fight_pkg::move_cmd_t cmd1;
    fight_pkg::move_cmd_t cmd2;
    fight_pkg::attack_t   attack1;
    fight_pkg::attack_t   attack2;
    fight_pkg::pos_t      pos1;
    fight_pkg::pos_t      pos2;
    fight_pkg::contact_t  contact;
    fight_pkg::health_t   health1;
    fight_pkg::health_t   health2;
    fight_pkg::winner_t   winner;
    logic                 round_over;
    logic                 stun1;
    logic                 stun2;
    logic                 round_restart;
    logic                 p2_toward_right;

    // --------------------------------------------------------------------------
    // pads to commands
    // --------------------------------------------------------------------------
    player_control u_ctrl1 (
        .CLK_20Hz (CLK_20Hz),
        .rst_n    (rst_n),
        .pad      (pad1),
        .stunned  (stun1),
        .frozen   (round_over),
        .cmd      (cmd1),
        .attack   (attack1)
    );

    player_control u_ctrl2 (
        .CLK_20Hz (CLK_20Hz),
        .rst_n    (rst_n),
        .pad      (pad2),
        .stunned  (stun2),
        .frozen   (round_over),
        .cmd      (cmd2),
        .attack   (attack2)
    );

    // --------------------------------------------------------------------------
    // movement and contact
    // --------------------------------------------------------------------------
    // p2 sees its opponent on the right when p1 faces left
    assign p2_toward_right = !contact.p1_facing_right;

    player_physics #(.START_X(`FIGHT_P1_START_X)) u_phys1 (
        .CLK_20Hz      (CLK_20Hz),
        .rst_n         (rst_n),
        .round_restart (round_restart),
        .cmd           (cmd1),
        .contact       (contact),
        .toward_right  (contact.p1_facing_right),
        .pos           (pos1)
    );

    player_physics #(.START_X(`FIGHT_P2_START_X)) u_phys2 (
        .CLK_20Hz      (CLK_20Hz),
        .rst_n         (rst_n),
        .round_restart (round_restart),
        .cmd           (cmd2),
        .contact       (contact),
        .toward_right  (p2_toward_right),
        .pos           (pos2)
    );

    contact_detect u_contact (
        .p1_pos  (pos1),
        .p2_pos  (pos2),
        .contact (contact)
    );

    round_referee u_referee (
        .CLK_20Hz       (CLK_20Hz),
        .rst_n          (rst_n),
        .restart_sw     (restart_sw),
        .restart_attack (pad1.attack),
        .contact        (contact),
        .p1_attack      (attack1),
        .p2_attack      (attack2),
        .health1        (health1),
        .health2        (health2),
        .winner         (winner),
        .round_over     (round_over),
        .stun1          (stun1),
        .stun2          (stun2),
        .round_restart  (round_restart)
    );

    assign view.p1_pos    = pos1;
    assign view.p2_pos    = pos2;
    assign view.health1   = health1;
    assign view.health2   = health2;
    assign view.winner    = winner;
    assign view.contact   = contact;
    assign view.p1_attack = attack1;
    assign view.p2_attack = attack2;

endmodule

//--- hw/round_referee.sv
`timescale 1ns/1ps
`include "fight_settings.svh"

module round_referee (
    input  logic                 CLK_20Hz,
    input  logic                 rst_n,
    input  logic                 restart_sw,
    input  logic                 restart_attack,
    input  fight_pkg::contact_t  contact,
    input  fight_pkg::attack_t   p1_attack,
    input  fight_pkg::attack_t   p2_attack,
    output fight_pkg::health_t   health1,
    output fight_pkg::health_t   health2,
    output fight_pkg::winner_t   winner,
    output logic                 round_over,
    output logic                 stun1,
    output logic                 stun2,
    output logic                 round_restart
);

    localparam fight_pkg::health_t health_max = fight_pkg::health_t'(`FIGHT_HEALTH_MAX);
    localparam int stun_w = $clog2(`FIGHT_STUN_TICKS + 1);
    localparam logic [stun_w-1:0] stun_load = stun_w'(`FIGHT_STUN_TICKS);
    localparam int hold_w = $clog2(`FIGHT_RESTART_TICKS + 2);
    localparam logic [hold_w-1:0] hold_done = hold_w'(`FIGHT_RESTART_TICKS);
    localparam logic [hold_w-1:0] hold_top  = hold_w'(`FIGHT_RESTART_TICKS + 1);

    fight_pkg::attack_t  p1_prev;
    fight_pkg::attack_t  p2_prev;
    fight_pkg::health_t  health1_q;
    fight_pkg::health_t  health2_q;
    fight_pkg::health_t  health1_d;
    fight_pkg::health_t  health2_d;
    fight_pkg::winner_t  winner_q;
    logic [stun_w-1:0]   stun1_cnt;
    logic [stun_w-1:0]   stun2_cnt;
    logic [hold_w-1:0]   hold_cnt;
    logic                hit1;
    logic                hit2;
    logic                hold_req;

    function automatic fight_pkg::health_t take_hit(input fight_pkg::health_t health,
                                                    input fight_pkg::attack_t kind);
        fight_pkg::health_t dmg;
        case (kind)
            fight_pkg::attack_normal:  dmg = fight_pkg::health_t'(`FIGHT_DMG_NORMAL);
            fight_pkg::attack_special: dmg = fight_pkg::health_t'(`FIGHT_DMG_SPECIAL);
            fight_pkg::attack_super:   dmg = fight_pkg::health_t'(`FIGHT_DMG_SUPER);
            default:                   dmg = '0;
        endcase
        return (health > dmg) ? health - dmg : '0;
    endfunction

    // --------------------------------------------------------------------------
    // hits land on the first tick of an attack only
    // --------------------------------------------------------------------------
    assign round_over = winner_q != fight_pkg::win_none;
    assign hit2 = (p1_attack != fight_pkg::attack_none) && (p1_prev == fight_pkg::attack_none)
                  && contact.in_range && !round_over;
    assign hit1 = (p2_attack != fight_pkg::attack_none) && (p2_prev == fight_pkg::attack_none)
                  && contact.in_range && !round_over;
    assign health1_d = hit1 ? take_hit(health1_q, p2_attack) : health1_q;
    assign health2_d = hit2 ? take_hit(health2_q, p1_attack) : health2_q;

    always_ff @(posedge CLK_20Hz or negedge rst_n)
    begin
        if (!rst_n)
        begin
            health1_q <= health_max;
            health2_q <= health_max;
            winner_q  <= fight_pkg::win_none;
            stun1_cnt <= '0;
            stun2_cnt <= '0;
        end
        else if (round_restart)
        begin
            health1_q <= health_max;
            health2_q <= health_max;
            winner_q  <= fight_pkg::win_none;
            stun1_cnt <= '0;
            stun2_cnt <= '0;
        end
        else
        begin
            health1_q <= health1_d;
            health2_q <= health2_d;
            // winner is taken from the new healths, same edge as the knockout
            if (!round_over)
            begin
                if ((health1_d == '0) && (health2_d == '0))
                begin
                    winner_q <= fight_pkg::win_draw;
                end
                else if (health1_d == '0)
                begin
                    winner_q <= fight_pkg::win_p2;
                end
                else if (health2_d == '0)
                begin
                    winner_q <= fight_pkg::win_p1;
                end
            end
            stun1_cnt <= hit1 ? stun_load : ((stun1_cnt != '0) ? stun1_cnt - 1'b1 : '0);
            stun2_cnt <= hit2 ? stun_load : ((stun2_cnt != '0) ? stun2_cnt - 1'b1 : '0);
        end
    end

    // --------------------------------------------------------------------------
    // hold-to-restart, saturates one past done so the pulse fires once
    // --------------------------------------------------------------------------
    assign hold_req = restart_sw || (restart_attack && round_over);

    always_ff @(posedge CLK_20Hz or negedge rst_n)
    begin
        if (!rst_n)
        begin
            p1_prev       <= fight_pkg::attack_none;
            p2_prev       <= fight_pkg::attack_none;
            hold_cnt      <= '0;
            round_restart <= 1'b0;
        end
        else
        begin
            p1_prev       <= p1_attack;
            p2_prev       <= p2_attack;
            round_restart <= hold_cnt == hold_done;
            if (!hold_req)
            begin
                hold_cnt <= '0;
            end
            else if (hold_cnt != hold_top)
            begin
                hold_cnt <= hold_cnt + 1'b1;
            end
        end
    end

    assign health1 = health1_q;
    assign health2 = health2_q;
    assign winner  = winner_q;
    assign stun1   = stun1_cnt != '0;
    assign stun2   = stun2_cnt != '0;

endmodule

//--- hw/player_physics.sv
`timescale 1ns/1ps
`include "fight_settings.svh"

module player_physics #(
    parameter int START_X = `FIGHT_P1_START_X
) (
    input  logic                  CLK_20Hz,
    input  logic                  rst_n,
    input  logic                  round_restart,
    input  fight_pkg::move_cmd_t  cmd,
    input  fight_pkg::contact_t   contact,
    input  logic                  toward_right,
    output fight_pkg::pos_t       pos
);

    localparam fight_pkg::coord_t start_x  = fight_pkg::coord_t'(START_X);
    localparam fight_pkg::coord_t ground_y = fight_pkg::coord_t'(`FIGHT_GROUND_Y);
    localparam fight_pkg::coord_t x_max    =
        fight_pkg::coord_t'(`FIGHT_ARENA_W - `FIGHT_SPRITE_W);
    localparam int air_w = $clog2(2 * `FIGHT_JUMP_TICKS);
    localparam logic [air_w-1:0] rise_ticks = air_w'(`FIGHT_JUMP_TICKS);
    localparam logic [air_w-1:0] last_tick  = air_w'(2 * `FIGHT_JUMP_TICKS - 1);

    fight_pkg::pos_t   pos_q;
    fight_pkg::coord_t x_next;
    logic [air_w-1:0]  air_cnt;
    logic              phase;
    logic              approach_ok;
    logic              step_left;
    logic              step_right;

    // inside hit range only one fighter closes in per tick, chosen by phase,
    // so two simultaneous steps can never push the gap under a sprite width
    assign approach_ok = !contact.touching && (!contact.in_range || (phase == toward_right));
    assign step_left   = cmd.left && !cmd.right && (pos_q.x != '0)
                         && (toward_right || approach_ok);
    assign step_right  = cmd.right && !cmd.left && (pos_q.x < x_max)
                         && (!toward_right || approach_ok);

    always_comb
    begin
        x_next = pos_q.x;
        if (step_left)
        begin
            x_next = pos_q.x - 1'b1;
        end
        else if (step_right)
        begin
            x_next = pos_q.x + 1'b1;
        end
    end

    // jump rises for rise_ticks then falls the same number back to the floor
    always_ff @(posedge CLK_20Hz or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pos_q.x <= start_x;
            pos_q.y <= ground_y;
            air_cnt <= '0;
            phase   <= 1'b0;
        end
        else if (round_restart)
        begin
            pos_q.x <= start_x;
            pos_q.y <= ground_y;
            air_cnt <= '0;
            phase   <= 1'b0;
        end
        else
        begin
            phase   <= !phase;
            pos_q.x <= x_next;
            if ((air_cnt != '0) || cmd.jump)
            begin
                pos_q.y <= (air_cnt < rise_ticks) ? pos_q.y - 1'b1 : pos_q.y + 1'b1;
                air_cnt <= (air_cnt == last_tick) ? '0 : air_cnt + 1'b1;
            end
        end
    end

    assign pos = pos_q;

endmodule

//--- hw/player_control.sv
`timescale 1ns/1ps

module player_control (
    input  logic                  CLK_20Hz,
    input  logic                  rst_n,
    input  fight_pkg::pad_t       pad,
    input  logic                  stunned,
    input  logic                  frozen,
    output fight_pkg::move_cmd_t  cmd,
    output fight_pkg::attack_t    attack
);

    fight_pkg::move_cmd_t cmd_d;
    fight_pkg::move_cmd_t cmd_q;
    fight_pkg::attack_t   attack_d;
    fight_pkg::attack_t   attack_q;
    logic                 hold;

    // button decode, up wins over down for the combo
    always_comb
    begin
        cmd_d.left  = pad.left;
        cmd_d.right = pad.right;
        cmd_d.jump  = pad.up;
        if (!pad.attack)
        begin
            attack_d = fight_pkg::attack_none;
        end
        else if (pad.up)
        begin
            attack_d = fight_pkg::attack_super;
        end
        else if (pad.down)
        begin
            attack_d = fight_pkg::attack_special;
        end
        else
        begin
            attack_d = fight_pkg::attack_normal;
        end
    end

    always_ff @(posedge CLK_20Hz or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cmd_q    <= '0;
            attack_q <= fight_pkg::attack_none;
        end
        else
        begin
            cmd_q    <= cmd_d;
            attack_q <= attack_d;
        end
    end

    // a stunned fighter or a finished round takes no input
    assign hold   = stunned || frozen;
    assign cmd    = hold ? '0 : cmd_q;
    assign attack = hold ? fight_pkg::attack_none : attack_q;

endmodule

//--- hw/contact_detect.sv
`timescale 1ns/1ps
`include "fight_settings.svh"

module contact_detect (
    input  fight_pkg::pos_t      p1_pos,
    input  fight_pkg::pos_t      p2_pos,
    output fight_pkg::contact_t  contact
);

    localparam fight_pkg::coord_t touch_gap = fight_pkg::coord_t'(`FIGHT_SPRITE_W);
    localparam fight_pkg::coord_t hit_gap   = fight_pkg::coord_t'(`FIGHT_HIT_RANGE);

    logic              p1_left;
    fight_pkg::coord_t gap;

    // --------------------------------------------------------------------------
    // horizontal only, a jump does not clear the opponent
    // --------------------------------------------------------------------------
    assign p1_left = p1_pos.x < p2_pos.x;

    always_comb
    begin
        if (p1_left)
        begin
            gap = p2_pos.x - p1_pos.x;
        end
        else
        begin
            gap = p1_pos.x - p2_pos.x;
        end
    end

    assign contact.touching        = gap <= touch_gap;
    assign contact.in_range        = gap <= hit_gap;
    assign contact.p1_facing_right = p1_left;

endmodule

//--- hw/fight_pkg.sv
package fight_pkg;

    typedef logic [6:0] coord_t;
    typedef logic [8:0] health_t;

    // raw buttons of one player
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic attack;
    } pad_t;

    typedef enum logic [1:0] {
        attack_none,
        attack_normal,
        attack_special,
        attack_super
    } attack_t;

    typedef struct packed {
        logic left;
        logic right;
        logic jump;
    } move_cmd_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pos_t;

    typedef enum logic [1:0] {
        win_none,
        win_p1,
        win_p2,
        win_draw
    } winner_t;

    typedef struct packed {
        logic touching;
        logic in_range;
        logic p1_facing_right;
    } contact_t;

    // everything the outside world sees of the game
    typedef struct packed {
        pos_t    p1_pos;
        pos_t    p2_pos;
        health_t health1;
        health_t health2;
        winner_t winner;
        contact_t contact;
        attack_t p1_attack;
        attack_t p2_attack;
    } game_view_t;

endpackage

//--- hw/fight_settings.svh
`ifndef FIGHT_SETTINGS_SVH
`define FIGHT_SETTINGS_SVH

// --------------------------------------------------------------------------
// arena geometry, in pixels
// --------------------------------------------------------------------------
`define FIGHT_ARENA_W        96
`define FIGHT_SPRITE_W       12
`define FIGHT_GROUND_Y       48
`define FIGHT_P1_START_X     10
`define FIGHT_P2_START_X     74

// ticks spent rising, and again falling
`define FIGHT_JUMP_TICKS     6
`define FIGHT_HIT_RANGE      16

// --------------------------------------------------------------------------
// combat
// --------------------------------------------------------------------------
`define FIGHT_HEALTH_MAX     100
`define FIGHT_DMG_NORMAL     5
`define FIGHT_DMG_SPECIAL    10
`define FIGHT_DMG_SUPER      20
`define FIGHT_STUN_TICKS     3
`define FIGHT_RESTART_TICKS  40

`endif
